// ==== logic/upscan_ctrl.sv ====
`timescale 1ns/10ps

module upscan_ctrl (
    input  logic                           INCLOCK,
    input  logic                           reset,
    // Source line side
    input  logic                           line_start,
    input  logic                           src_line_odd,
    input  logic                           src_we,
    input  video_timing_pkg::xpos_t        src_x,
    input  video_pixel_pkg::color_t        src_pixel,
    // Buffer read data
    input  video_pixel_pkg::color_t        buf0_q,
    input  video_pixel_pkg::color_t        buf1_q,
    // Buffer ports
    output video_pixel_pkg::linebuf_port_t buf0_port,
    output video_pixel_pkg::linebuf_port_t buf1_port,
    // Double-rate output
    output video_pixel_pkg::vga_out_t      vga
);

    import video_timing_pkg::*;
    import video_pixel_pkg::*;

    // Bank taking the current source line
    logic wr_bank;

    // Set by the first line_start after reset
    logic running;

    // Double-rate read count, two passes per source line
    xpos_t rd_cnt;

    // Output stage, aligned with the buffer's latched address
    logic de_q;
    logic hsync_q;
    logic rd_bank_q;

    // Decoded from the current count
    logic de_next;
    logic hsync_next;
    logic cnt_wrap;

    // Port contents before steering
    linebuf_port_t write_side;
    linebuf_port_t read_side;

    // Pixel from the bank being shown
    color_t rd_pixel;

    // ------------------------------------------------------------
    // Bank register and running flag
    // ------------------------------------------------------------
    always_ff @(posedge INCLOCK) begin
        if (reset) begin
            wr_bank <= 1'b0;
            running <= 1'b0;
        end else if (line_start) begin
            // Bank sampled only here
            wr_bank <= src_line_odd;
            running <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Read counter
    // ------------------------------------------------------------
    assign cnt_wrap = (rd_cnt == xpos_t'(VGA_LINE_CLKS - 1));

    always_ff @(posedge INCLOCK) begin
        if (reset) begin
            rd_cnt <= '0;
        end else if (line_start) begin
            // Restart, even mid-line
            rd_cnt <= '0;
        end else if (running) begin
            if (cnt_wrap) begin
                // Second pass of the same line
                rd_cnt <= '0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Enable and sync decode
    // ------------------------------------------------------------
    assign de_next    = (rd_cnt < xpos_t'(LINE_PIXELS));
    assign hsync_next = (rd_cnt >= xpos_t'(HSYNC_START))
                     && (rd_cnt <= xpos_t'(HSYNC_LAST));

    // Registered on the edge the buffer latches the count
    always_ff @(posedge INCLOCK) begin
        if (reset) begin
            de_q      <= 1'b0;
            hsync_q   <= 1'b0;
            rd_bank_q <= 1'b0;
        end else begin
            de_q      <= running && de_next;
            hsync_q   <= running && hsync_next;
            // Read bank is opposite the write bank
            rd_bank_q <= ~wr_bank;
        end
    end

    // ------------------------------------------------------------
    // Buffer port steering
    // ------------------------------------------------------------
    always_comb begin
        // Source writes, dropped until the first line
        write_side.addr  = src_x;
        write_side.we    = src_we && running;
        write_side.wdata = src_pixel;

        // Read side never writes
        read_side.addr  = rd_cnt;
        read_side.we    = 1'b0;
        read_side.wdata = '0;

        if (wr_bank) begin
            buf0_port = read_side;
            buf1_port = write_side;
        end else begin
            buf0_port = write_side;
            buf1_port = read_side;
        end
    end

    // ------------------------------------------------------------
    // Output select and blanking
    // ------------------------------------------------------------
    assign rd_pixel = rd_bank_q ? buf1_q : buf0_q;

    always_comb begin
        vga.hsync = hsync_q;
        vga.de    = de_q;
        // Zero outside the active region
        vga.pixel = de_q ? rd_pixel : '0;
    end

endmodule

// ==== logic/vdp_linebuf.sv ====
`timescale 1ns/10ps

module vdp_linebuf (
    input  logic                          INCLOCK,
    input  video_pixel_pkg::linebuf_port_t port,
    output video_pixel_pkg::color_t        q
);

    import video_timing_pkg::*;
    import video_pixel_pkg::*;

    // One stored entry per active pixel
    stored_t mem [LINE_PIXELS];

    // Address seen on the last edge
    xpos_t addr_q;

    // ------------------------------------------------------------
    // Write and address latch
    // ------------------------------------------------------------
    always_ff @(posedge INCLOCK) begin
        if (port.we) begin
            // Upper five bits only
            mem[port.addr] <= port.wdata[COLOR_W-1:1];
        end
        addr_q <= port.addr;
    end

    // Read from the latched address, bit 0 returns as zero
    assign q = {mem[addr_q], 1'b0};

endmodule

// ==== logic/vga_upscan.sv ====
`timescale 1ns/10ps

module vga_upscan (
    input  logic                      INCLOCK,
    input  logic                      reset,
    // Source line, one pixel per write strobe
    input  logic                      line_start,
    input  logic                      src_line_odd,
    input  logic                      src_we,
    input  video_timing_pkg::xpos_t   src_x,
    input  video_pixel_pkg::color_t   src_pixel,
    // Double-rate output
    output video_pixel_pkg::vga_out_t vga
);

    import video_pixel_pkg::*;

    // ------------------------------------------------------------
    // Buffer wiring
    // ------------------------------------------------------------

    // Ports steered by the controller
    linebuf_port_t buf0_port;
    linebuf_port_t buf1_port;

    // Read data from the latched addresses
    color_t buf0_q;
    color_t buf1_q;

    // Bank select, counter, sync and blanking
    upscan_ctrl i_ctrl (
        .INCLOCK      (INCLOCK),
        .reset        (reset),
        .line_start   (line_start),
        .src_line_odd (src_line_odd),
        .src_we       (src_we),
        .src_x        (src_x),
        .src_pixel    (src_pixel),
        .buf0_q       (buf0_q),
        .buf1_q       (buf1_q),
        .buf0_port    (buf0_port),
        .buf1_port    (buf1_port),
        .vga          (vga)
    );

    // Even bank
    vdp_linebuf i_buf0 (
        .INCLOCK (INCLOCK),
        .port    (buf0_port),
        .q       (buf0_q)
    );

    // Odd bank
    vdp_linebuf i_buf1 (
        .INCLOCK (INCLOCK),
        .port    (buf1_port),
        .q       (buf1_q)
    );

endmodule

// ==== logic/video_pixel_pkg.sv ====
package video_pixel_pkg;

    // ------------------------------------------------------------
    // Color widths
    // ------------------------------------------------------------

    // Color as delivered by the source and as shown
    localparam int COLOR_W = 6;

    // Color as kept in a line buffer, bit 0 dropped
    localparam int STORED_W = COLOR_W - 1;

    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [STORED_W-1:0] stored_t;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------

    // One line buffer's shared address port
    typedef struct packed {
        video_timing_pkg::xpos_t addr;
        // Write strobe, low on the read bank
        logic we;
        color_t wdata;
    } linebuf_port_t;

    // Double-rate VGA output
    typedef struct packed {
        logic hsync;
        // Display enable, active region only
        logic de;
        // Zero outside the active region
        color_t pixel;
    } vga_out_t;

endpackage

// ==== logic/video_timing_pkg.sv ====
package video_timing_pkg;

    // ------------------------------------------------------------
    // Horizontal timing of the upscan converter
    // ------------------------------------------------------------

    // Width of any horizontal position or count
    localparam int XPOS_W = 10;

    // Horizontal pixel position, also the double-rate read count
    typedef logic [XPOS_W-1:0] xpos_t;

    // Active pixels, stored and shown
    localparam int LINE_PIXELS = 640;

    // Clocks per output line at double line rate
    localparam int VGA_LINE_CLKS = 684;

    // Nominal source line, two output lines long
    localparam int SRC_LINE_CLKS = 2 * VGA_LINE_CLKS;

    // ------------------------------------------------------------
    // Horizontal sync window
    // ------------------------------------------------------------

    // First count with sync active
    localparam int HSYNC_START = 648;

    // Sync width in counts
    localparam int HSYNC_LEN = 24;

    // Last count with sync active
    localparam int HSYNC_LAST = HSYNC_START + HSYNC_LEN - 1;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build the upscan testbench with Verilator and run it
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module vga_upscan_tb -Mdir obj_dir \
    && ./obj_dir/Vvga_upscan_tb > "$LOG" 2>&1

# Verdict from the simulation log
grep -q "TEST FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "TEST OK" "$LOG" || { echo "no verdict found in $LOG"; exit 1; }
echo "simulation passed"

// ==== verif/vga_upscan_props.sv ====
`timescale 1ns/10ps

module vga_upscan_props (
    input logic                           INCLOCK,
    input logic                           reset,
    input logic                           wr_bank,
    input video_pixel_pkg::linebuf_port_t buf0_port,
    input video_pixel_pkg::linebuf_port_t buf1_port,
    input video_pixel_pkg::vga_out_t      vga
);

    // ------------------------------------------------------------
    // Output timing
    // ------------------------------------------------------------

    // Sync lies in the blanking region
    a_de_hsync_apart: assert property (
        @(posedge INCLOCK) disable iff (reset)
        !(vga.de && vga.hsync)
    ) else $error("de and hsync high in the same cycle");

    // ------------------------------------------------------------
    // Buffer ports
    // ------------------------------------------------------------

    // Only the write bank takes data
    a_single_writer: assert property (
        @(posedge INCLOCK) disable iff (reset)
        !(buf0_port.we && buf1_port.we)
    ) else $error("both line buffers written in the same cycle");

    // Bank 0 is read while wr_bank is set
    a_buf0_read_no_write: assert property (
        @(posedge INCLOCK) disable iff (reset)
        wr_bank |-> !buf0_port.we
    ) else $error("buffer 0 written while it is the read bank");

    a_buf1_read_no_write: assert property (
        @(posedge INCLOCK) disable iff (reset)
        !wr_bank |-> !buf1_port.we
    ) else $error("buffer 1 written while it is the read bank");

endmodule

bind upscan_ctrl vga_upscan_props i_props (
    .INCLOCK   (INCLOCK),
    .reset     (reset),
    .wr_bank   (wr_bank),
    .buf0_port (buf0_port),
    .buf1_port (buf1_port),
    .vga       (vga)
);

// ==== verif/vga_upscan_tb.sv ====
`timescale 1ns/10ps

module vga_upscan_tb;

    import video_timing_pkg::*;
    import video_pixel_pkg::*;

    // ------------------------------------------------------------
    // Testbench constants
    // ------------------------------------------------------------
    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 5;
    localparam int          IDLE_CYCLES  = 24;
    localparam int          NUM_ROWS     = 10;
    localparam logic [31:0] SEED         = 32'h054c8f1a;
    localparam int          WATCHDOG_NS  = 200_000;

    // How a row fills its written span
    typedef enum logic [1:0] {
        PAT_RAMP,
        PAT_CONST,
        PAT_RAND
    } pattern_t;

    // One source line of stimulus
    typedef struct packed {
        logic        bank;
        xpos_t       first;
        xpos_t       last;
        pattern_t    kind;
        // Constant value or ramp offset
        color_t      value;
        logic [11:0] line_len;
    } line_row_t;

    logic     INCLOCK;
    logic     reset;
    logic     line_start;
    logic     src_line_odd;
    logic     src_we;
    xpos_t    src_x;
    color_t   src_pixel;
    vga_out_t vga;

    // Reference copy of both banks with bit 0 cleared
    color_t model_mem [2][LINE_PIXELS];
    // Entries written at least once
    bit     known [2][LINE_PIXELS];

    logic [31:0] rng_state;
    bit          run_done;

    // Previous line still shown for two samples after line_start
    bit   prev_valid;
    logic prev_rd_bank;
    int   prev_len;

    vga_upscan i_dut (
        .INCLOCK      (INCLOCK),
        .reset        (reset),
        .line_start   (line_start),
        .src_line_odd (src_line_odd),
        .src_we       (src_we),
        .src_x        (src_x),
        .src_pixel    (src_pixel),
        .vga          (vga)
    );

    // 4 ns clock
    initial begin
        INCLOCK = 1'b0;
        forever #(CLK_PERIOD / 2) INCLOCK = ~INCLOCK;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each falling edge waited for at most two periods
    task automatic wait_falling(input int n);
        int     seen;
        longint t0;
        seen = 0;
        while (seen < n) begin
            t0 = $time;
            fork
                @(negedge INCLOCK);
                #(CLK_PERIOD * 2);
            join_any
            disable fork;
            if ($time - t0 >= longint'(CLK_PERIOD * 2)) begin
                fail_run("no falling clock edge within two clock periods");
            end
            seen++;
        end
    endtask

    function automatic line_row_t make_row(input logic bank, input int first,
                                           input int last, input pattern_t kind,
                                           input int value, input int len);
        line_row_t row;
        row.bank     = bank;
        row.first    = xpos_t'(first);
        row.last     = xpos_t'(last);
        row.kind     = kind;
        row.value    = color_t'(value);
        row.line_len = 12'(len);
        return row;
    endfunction

    // Stimulus table with ping-pong banks
    function automatic line_row_t table_row(input int idx);
        case (idx)
            0: return make_row(1'b0, 0, 639, PAT_RAMP, 0, SRC_LINE_CLKS);
            // All ones shows as 3e
            1: return make_row(1'b1, 0, 639, PAT_CONST, 'h3f, SRC_LINE_CLKS);
            2: return make_row(1'b0, 0, 639, PAT_RAND, 0, SRC_LINE_CLKS);
            // Partial write over the all-ones line
            3: return make_row(1'b1, 100, 299, PAT_RAMP, 7, SRC_LINE_CLKS);
            4: return make_row(1'b0, 0, 639, PAT_CONST, 'h15, SRC_LINE_CLKS);
            // Short line with the next line_start in pass two
            5: return make_row(1'b1, 0, 639, PAT_RAND, 0, 900);
            6: return make_row(1'b0, 0, 639, PAT_RAMP, 21, SRC_LINE_CLKS);
            7: return make_row(1'b1, 0, 639, PAT_CONST, 'h01, SRC_LINE_CLKS);
            8: return make_row(1'b0, 600, 639, PAT_RAND, 0, SRC_LINE_CLKS);
            // No writes while bank 0 is shown
            default: return make_row(1'b1, 1, 0, PAT_CONST, 0, SRC_LINE_CLKS);
        endcase
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_pixel(input string what, input int c,
                               input color_t got, input color_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s at count %0d: got 0x%h, expected 0x%h",
                               what, c, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input int c,
                              input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s at count %0d: got 0x%h, expected 0x%h",
                               what, c, got, exp));
        end
    endtask

    // Output expected for read count c of a bank
    task automatic check_count(input logic bank, input int c);
        logic exp_de;
        logic exp_hs;
        exp_de = (c < LINE_PIXELS);
        exp_hs = (c >= HSYNC_START) && (c < HSYNC_START + HSYNC_LEN);
        check_flag("vga.de", c, vga.de, exp_de);
        check_flag("vga.hsync", c, vga.hsync, exp_hs);
        if (!exp_de) begin
            check_pixel("vga.pixel", c, vga.pixel, '0);
        end else if (known[bank][c]) begin
            check_pixel("vga.pixel", c, vga.pixel, model_mem[bank][c]);
        end
    endtask

    // Nothing shown before the first line
    task automatic check_idle();
        check_flag("vga.de", -1, vga.de, 1'b0);
        check_flag("vga.hsync", -1, vga.hsync, 1'b0);
        check_pixel("vga.pixel", -1, vga.pixel, '0);
    endtask

    // Sample t of a line reflects the edge before it
    task automatic check_outputs(input logic rd_bank, input int t);
        if (t >= 2) begin
            check_count(rd_bank, (t - 2) % VGA_LINE_CLKS);
        end else if (prev_valid) begin
            // Tail of the previous line
            check_count(prev_rd_bank, (prev_len - 2 + t) % VGA_LINE_CLKS);
        end else begin
            check_idle();
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------
    task automatic drive_cycle(input line_row_t row, input int t);
        int     pos;
        color_t value;
        pos          = int'(row.first) + t - 1;
        line_start   = (t == 0);
        src_line_odd = row.bank;
        if (t >= 1 && pos <= int'(row.last)) begin
            case (row.kind)
                PAT_RAMP: value = color_t'(pos + int'(row.value));
                PAT_CONST: value = row.value;
                default: begin
                    rng_state = xorshift32(rng_state);
                    value     = rng_state[13:8];
                end
            endcase
            src_we    = 1'b1;
            src_x     = xpos_t'(pos);
            src_pixel = value;
            // Bit 0 never stored
            model_mem[row.bank][pos] = value & color_t'('h3e);
            known[row.bank][pos]     = 1'b1;
        end else begin
            src_we    = 1'b0;
            src_x     = '0;
            src_pixel = '0;
        end
    endtask

    // Hang limit independent of the clock
    initial begin
        int waited;
        waited = 0;
        while (!run_done && waited < WATCHDOG_NS) begin
            #1000;
            waited += 1000;
        end
        if (!run_done) begin
            fail_run("watchdog expired before the run finished");
        end
    end

    initial begin
        line_row_t row;
        int        row_len;
        reset        = 1'b1;
        line_start   = 1'b0;
        src_line_odd = 1'b0;
        src_we       = 1'b0;
        src_x        = '0;
        src_pixel    = '0;
        rng_state    = SEED;
        run_done     = 1'b0;
        prev_valid   = 1'b0;
        prev_rd_bank = 1'b0;
        prev_len     = 0;
        for (int b = 0; b < 2; b++) begin
            for (int x = 0; x < LINE_PIXELS; x++) begin
                known[b][x] = 1'b0;
            end
        end

        wait_falling(RESET_CYCLES);
        reset = 1'b0;

        // Idle before the first line_start
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            check_idle();
            wait_falling(1);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row     = table_row(r);
            row_len = int'(row.line_len);
            for (int t = 0; t < row_len; t++) begin
                check_outputs(~row.bank, t);
                drive_cycle(row, t);
                wait_falling(1);
            end
            prev_valid   = 1'b1;
            prev_rd_bank = ~row.bank;
            prev_len     = row_len;
        end

        src_we   = 1'b0;
        run_done = 1'b1;
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/video_timing_pkg.sv
logic/video_pixel_pkg.sv
logic/vdp_linebuf.sv
logic/upscan_ctrl.sv
logic/vga_upscan.sv
verif/vga_upscan_props.sv
verif/vga_upscan_tb.sv
